// File: sine_quarter.hex
// Quarter-wave sine magnitudes, one 15-bit hex word per line, index 0 to 31 rising to the peak.
0000
0648
0C8C
12C8
18F9
1F1A
2528
2B1F
30FB
36BA
3C56
41CE
471C
4C3F
5133
55F5
5A82
5ED7
62F1
66CF
6A6D
6DC9
70E2
73B5
7641
7883
7A7C
7C29
7D89
7E9C
7F61
7FD8

// File: compile.f
+incdir+.
synth_pkg.sv
note_dispatch.sv
osc_voice.sv
voice_mixer.sv
synth_top.sv
tb_synth.sv

// File: Makefile
# Verilator build and run of the voice bank testbench.
SIM := obj_dir/Vtb_synth
SRCS := synth_defs.svh synth_pkg.sv note_dispatch.sv osc_voice.sv voice_mixer.sv \
        synth_top.sv tb_synth.sv

.PHONY: all run clean

all: run

$(SIM): compile.f $(SRCS)
	verilator --binary --timing --top-module tb_synth -f compile.f

# The log decides the result, so a run without the pass line fails.
run: $(SIM) sine_quarter.hex
	./$(SIM) | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_synth.sv
`include "synth_defs.svh"

module tb_synth
  import synth_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int NV = `SYNTH_VOICES;
  localparam int GOT_DEPTH = 512;

  // One table row: an optional command, the samples to collect and the credit delay.
  // A negative delay asks for random spacing between credit returns.
  typedef struct packed {
    logic      has_cmd;
    note_cmd_t cmd;
    int        nsamp;
    int        delay;
  } row_t;

  logic                              clk;
  logic                              reset;
  logic                              cmd_valid;
  note_cmd_t                         cmd;
  logic                              credit_return;
  logic                              sample_valid;
  logic signed [`SYNTH_SAMPLE_W-1:0] sample;

  row_t        rows [$];
  string       names [$];
  logic [14:0] sine_ref [0:31];
  logic [15:0] got [0:GOT_DEPTH-1];

  // Reference voices.
  int    m_phase [NV];
  int    m_key [NV];
  wave_t m_wave [NV];
  bit    m_active [NV];

  int     errors;
  int     flow_errors;
  int     total_received;
  int     total_returned;
  int     checked;
  int     expect_limit;
  int     cur_row;
  int     tests_passed;
  int     tests_failed;
  integer seed;
  bit     table_ready;

  synth_top i_dut (
    .clk           (clk),
    .reset         (reset),
    .cmd_valid     (cmd_valid),
    .cmd           (cmd),
    .credit_return (credit_return),
    .sample_valid  (sample_valid),
    .sample        (sample)
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  // Waveform value for phase p, following the wave rules directly.
  function automatic int wave_value(wave_t w, int p);
    int t;
    int idx;
    int v;
    v = 0;
    case (w)
      WAVE_SQUARE: v = ((p & 'h8000) != 0) ? -32767 : 32767;
      WAVE_SAW:    v = p - 32768;
      WAVE_TRI: begin
        t = p & 'h7FFF;
        if ((p & 'h4000) != 0) begin
          t = 'h7FFF - t;
        end
        v = 2 * t - 16384;
        if ((p & 'h8000) != 0) begin
          v = -v;
        end
      end
      WAVE_SINE: begin
        idx = (p >> 9) & 31;
        if ((p & 'h4000) != 0) begin
          idx = 31 - idx;
        end
        v = int'(sine_ref[idx]);
        if ((p & 'h8000) != 0) begin
          v = -v;
        end
      end
      default: v = 0;
    endcase
    return v;
  endfunction

  // One output sample: mix the active voices, then advance their phases.
  task automatic model_step(output int expected);
    int sum;
    sum = 0;
    for (int v = 0; v < NV; v++) begin
      if (m_active[v]) begin
        sum = sum + wave_value(m_wave[v], m_phase[v]);
        m_phase[v] = (m_phase[v] + m_key[v] * `SYNTH_INC_SCALE) & 'hFFFF;
      end
    end
    expected = sum >>> 2;
  endtask

  task automatic model_command(note_cmd_t c);
    int pick;
    pick = -1;
    for (int v = 0; v < NV; v++) begin
      if (pick < 0 && c.op == NOTE_ON && !m_active[v]) begin
        pick = v;
      end
      if (pick < 0 && c.op == NOTE_OFF && m_active[v] && m_key[v] == int'(c.key)) begin
        pick = v;
      end
    end
    // No free voice for a note on means the note is lost.
    if (pick >= 0 && c.op == NOTE_ON) begin
      m_active[pick] = 1'b1;
      m_phase[pick] = 0;
      m_key[pick] = int'(c.key);
      m_wave[pick] = c.wave;
    end else if (pick >= 0) begin
      m_active[pick] = 1'b0;
    end
  endtask

  task automatic add_row(string name, bit has_cmd, synth_op_t op, int key, wave_t wave,
                         int nsamp, int delay);
    row_t row;
    row.has_cmd = has_cmd;
    row.cmd.op = op;
    row.cmd.key = key[`SYNTH_KEY_W-1:0];
    row.cmd.wave = wave;
    row.nsamp = nsamp;
    row.delay = delay;
    rows.push_back(row);
    names.push_back(name);
  endtask

  task automatic build_table();
    add_row("idle after reset", 0, NOTE_OFF, 0, WAVE_SINE, 8, 2);
    add_row("sine note on", 1, NOTE_ON, 127, WAVE_SINE, 70, 0);
    add_row("sine note off", 1, NOTE_OFF, 127, WAVE_SINE, 4, 1);
    add_row("square note on", 1, NOTE_ON, 100, WAVE_SQUARE, 82, 0);
    add_row("square note off", 1, NOTE_OFF, 100, WAVE_SINE, 4, 0);
    add_row("saw note on", 1, NOTE_ON, 64, WAVE_SAW, 40, -1);
    add_row("saw note off", 1, NOTE_OFF, 64, WAVE_SINE, 4, 0);
    add_row("triangle note on", 1, NOTE_ON, 90, WAVE_TRI, 40, 0);
    add_row("triangle note off", 1, NOTE_OFF, 90, WAVE_SINE, 4, 0);
    add_row("fill voice 0", 1, NOTE_ON, 21, WAVE_SINE, 3, 0);
    add_row("fill voice 1", 1, NOTE_ON, 45, WAVE_SQUARE, 3, 0);
    add_row("fill voice 2", 1, NOTE_ON, 77, WAVE_SAW, 3, 0);
    add_row("fill voice 3", 1, NOTE_ON, 113, WAVE_TRI, 24, -1);
    add_row("fifth note dropped", 1, NOTE_ON, 60, WAVE_SINE, 16, 0);
    add_row("release held key", 1, NOTE_OFF, 45, WAVE_SINE, 12, 0);
    add_row("release unheld key", 1, NOTE_OFF, 33, WAVE_SINE, 8, 0);
    add_row("freed voice reused", 1, NOTE_ON, 88, WAVE_SAW, 16, -1);
    add_row("slow credit return", 0, NOTE_OFF, 0, WAVE_SINE, 12, 30);
  endtask

  // The consumer frees one buffered sample per credit, after the row's delay.
  task automatic return_credits(int count, int delay);
    int d;
    for (int i = 0; i < count; i++) begin
      wait (total_received > total_returned);
      d = delay;
      if (delay < 0) begin
        d = $unsigned($random(seed)) % 8;
      end
      repeat (d) @(negedge clk);
      credit_return = 1'b1;
      total_returned = total_returned + 1;
      @(negedge clk);
      credit_return = 1'b0;
    end
  endtask

  task automatic run_row(int r);
    int returns;
    int err_start;
    int flow_start;
    int expected;
    err_start = errors;
    flow_start = flow_errors;
    cur_row = r;
    expect_limit = expect_limit + rows[r].nsamp;
    // Commands go in only while the mixer is out of credits, so no step is in flight.
    if (rows[r].has_cmd) begin
      cmd_valid = 1'b1;
      cmd = rows[r].cmd;
      @(negedge clk);
      cmd_valid = 1'b0;
      cmd = '0;
      model_command(rows[r].cmd);
      repeat (4) @(negedge clk);
    end
    returns = rows[r].nsamp - (`SYNTH_CREDITS - (total_received - total_returned));
    fork
      return_credits(returns, rows[r].delay);
      begin
        for (int i = 0; i < rows[r].nsamp; i++) begin
          wait (total_received > checked);
          model_step(expected);
          if (got[checked] !== expected[15:0]) begin
            $display("Fail sample %0d: expected %h, actual %h", checked, expected[15:0],
                     got[checked]);
            errors = errors + 1;
          end
          checked = checked + 1;
        end
      end
    join
    // With all credits held, the output has to stay quiet.
    repeat (12) @(negedge clk);
    if (errors == err_start && flow_errors == flow_start) begin
      tests_passed = tests_passed + 1;
      $display("Test %0d (%s): pass, %0d samples", r, names[r], rows[r].nsamp);
    end else begin
      tests_failed = tests_failed + 1;
      $display("Test %0d (%s): failed with %0d errors", r, names[r],
               errors - err_start + flow_errors - flow_start);
    end
  endtask

  always @(negedge clk) begin
    if (reset && sample_valid) begin
      if (total_received < GOT_DEPTH) begin
        got[total_received] = sample;
      end
      total_received = total_received + 1;
      if (total_received - total_returned > `SYNTH_CREDITS) begin
        $display("More samples arrived than credits allow in test %0d", cur_row);
        flow_errors = flow_errors + 1;
      end
      if (total_received > expect_limit) begin
        $display("An extra sample arrived after the count requested by test %0d", cur_row);
        flow_errors = flow_errors + 1;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (table_ready);
    limit = 1000;
    foreach (rows[r]) begin
      limit = limit + rows[r].nsamp * 64;
    end
    repeat (limit) @(posedge clk);
    $display("Simulation stopped by the watchdog after %0d cycles", limit);
    $display("Test failures found");
    $finish;
  end

  initial begin : main
    reset = 1'b0;
    cmd_valid = 1'b0;
    cmd = '0;
    credit_return = 1'b0;
    seed = 43933;
    errors = 0;
    flow_errors = 0;
    total_received = 0;
    total_returned = 0;
    checked = 0;
    expect_limit = 0;
    cur_row = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int v = 0; v < NV; v++) begin
      m_phase[v] = 0;
      m_key[v] = 0;
      m_wave[v] = WAVE_SINE;
      m_active[v] = 1'b0;
    end
    $readmemh("sine_quarter.hex", sine_ref);
    build_table();
    table_ready = 1'b1;
    repeat (5) @(negedge clk);
    reset = 1'b1;
    for (int r = 0; r < rows.size(); r++) begin
      run_row(r);
    end
    $display("Summary: %0d passed, %0d failed, %0d samples, %0d mismatches, %0d flow errors",
             tests_passed, tests_failed, checked, errors, flow_errors);
    if (errors == 0 && flow_errors == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// File: synth_top.sv
`include "synth_defs.svh"

module synth_top
  import synth_pkg::*;
(
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              cmd_valid,
  input  note_cmd_t                         cmd,
  input  logic                              credit_return,
  output logic                              sample_valid,
  output logic signed [`SYNTH_SAMPLE_W-1:0] sample
);

  voice_ctrl_t   voice_ctrl    [`SYNTH_VOICES];
  voice_sample_t voice_samples [`SYNTH_VOICES];
  logic          step;

  note_dispatch u_dispatch (
    .clk        (clk),
    .reset      (reset),
    .cmd_valid  (cmd_valid),
    .cmd        (cmd),
    .voice_ctrl (voice_ctrl)
  );

  // All voices share the mixer's step pulse.
  for (genvar v = 0; v < `SYNTH_VOICES; v++) begin : g_voice
    osc_voice u_voice (
      .clk    (clk),
      .reset  (reset),
      .ctrl   (voice_ctrl[v]),
      .step   (step),
      .sample (voice_samples[v])
    );
  end

  voice_mixer u_mixer (
    .clk           (clk),
    .reset         (reset),
    .credit_return (credit_return),
    .voice_samples (voice_samples),
    .step          (step),
    .sample_valid  (sample_valid),
    .sample        (sample)
  );

endmodule

// File: voice_mixer.sv
`include "synth_defs.svh"

module voice_mixer
  import synth_pkg::*;
(
  input  logic                              clk,
  input  logic                              reset,
  input  logic                              credit_return,
  input  voice_sample_t                     voice_samples [`SYNTH_VOICES],
  output logic                              step,
  output logic                              sample_valid,
  output logic signed [`SYNTH_SAMPLE_W-1:0] sample
);

  localparam int NV = `SYNTH_VOICES;
  localparam int SW = `SYNTH_SAMPLE_W;
  localparam int CW = $clog2(`SYNTH_CREDITS + 1);

  logic [CW-1:0]        credits;
  logic [CW-1:0]        credits_next;
  logic                 step_d1;
  logic signed [SW+1:0] mix_sum;

  // A step spends a credit on the edge it is issued.
  assign credits_next = credits - CW'(step) + CW'(credit_return);

  // Step is registered, so it is only raised when the updated count still holds a credit.
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      credits      <= CW'(`SYNTH_CREDITS);
      step         <= 1'b0;
      step_d1      <= 1'b0;
      sample_valid <= 1'b0;
    end else begin
      credits      <= credits_next;
      step         <= (credits_next != '0);
      step_d1      <= step;
      sample_valid <= step_d1;
    end
  end

  // Voice samples are valid the cycle after step, which is when step_d1 is high.
  always_comb begin
    mix_sum = '0;
    for (int v = 0; v < NV; v++) begin
      if (voice_samples[v].active) begin
        mix_sum = mix_sum + {{2{voice_samples[v].value[SW-1]}}, voice_samples[v].value};
      end
    end
  end

  // Dropping the two low bits of the 18-bit sum is the arithmetic shift by 2.
  always_ff @(posedge clk) begin
    if (step_d1) begin
      sample <= mix_sum[SW+1:2];
    end
  end

  // Credits only come back for samples already sent, so the count stays bounded.
  a_credit_max: assert property (@(posedge clk) disable iff (!reset)
    credits <= CW'(`SYNTH_CREDITS))
    else $error("Credit count above limit");

  a_step_credit: assert property (@(posedge clk) disable iff (!reset)
    step |-> credits != '0)
    else $error("Step issued without a credit");

endmodule

// File: osc_voice.sv
`include "synth_defs.svh"

module osc_voice
  import synth_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  voice_ctrl_t   ctrl,
  input  logic          step,
  output voice_sample_t sample
);

  localparam int PW = `SYNTH_PHASE_W;
  localparam int SW = `SYNTH_SAMPLE_W;

  // Quarter-wave sine magnitudes, rising from zero to the peak.
  logic [14:0]             sine_rom [0:31];

  logic [PW-1:0]           phase;
  logic [PW-1:0]           inc;
  logic [`SYNTH_KEY_W-1:0] key_q;
  wave_t                   wave_q;
  logic                    active;

  logic [4:0]              sine_idx;
  logic [14:0]             sine_mag;
  logic [13:0]             tri_fold;
  logic signed [SW-1:0]    sine_val;
  logic signed [SW-1:0]    square_val;
  logic signed [SW-1:0]    saw_val;
  logic signed [SW-1:0]    tri_lin;
  logic signed [SW-1:0]    tri_val;
  logic signed [SW-1:0]    wave_val;

  initial begin
    $readmemh("sine_quarter.hex", sine_rom);
  end

  assign inc = PW'(key_q) * PW'(`SYNTH_INC_SCALE);

  // Sine: the second and fourth quarters read the table backwards.
  assign sine_idx = phase[14] ? ~phase[13:9] : phase[13:9];
  assign sine_mag = sine_rom[sine_idx];
  assign sine_val = phase[PW-1] ? -$signed({1'b0, sine_mag}) : $signed({1'b0, sine_mag});

  assign square_val = phase[PW-1] ? -16'sd32767 : 16'sd32767;

  // Offset binary to two's complement is a flip of the top bit.
  assign saw_val = $signed(phase - 16'h8000);

  // Triangle: fold the low bits, scale to 0..32766, centre, then mirror in the upper half.
  assign tri_fold = phase[14] ? ~phase[13:0] : phase[13:0];
  assign tri_lin  = $signed({1'b0, tri_fold, 1'b0}) - 16'sd16384;
  assign tri_val  = phase[PW-1] ? -tri_lin : tri_lin;

  always_comb begin
    case (wave_q)
      WAVE_SINE:   wave_val = sine_val;
      WAVE_SQUARE: wave_val = square_val;
      WAVE_SAW:    wave_val = saw_val;
      WAVE_TRI:    wave_val = tri_val;
      default:     wave_val = '0;
    endcase
  end

  // Load takes priority over a step in the same cycle.
  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      phase  <= '0;
      active <= 1'b0;
      sample <= '0;
    end else if (ctrl.load) begin
      phase  <= '0;
      active <= 1'b1;
    end else if (ctrl.rel) begin
      active <= 1'b0;
      sample <= '0;
    end else if (step && active) begin
      sample.active <= 1'b1;
      sample.value  <= wave_val;
      phase         <= phase + inc;
    end
  end

  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      key_q  <= ctrl.key;
      wave_q <= ctrl.wave;
    end
  end

  // The dispatcher must never start and stop this voice in the same cycle.
  a_load_rel: assert property (@(posedge clk) disable iff (!reset) !(ctrl.load && ctrl.rel))
    else $error("Load and release pulsed together");

endmodule

// File: note_dispatch.sv
`include "synth_defs.svh"

module note_dispatch
  import synth_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        cmd_valid,
  input  note_cmd_t   cmd,
  output voice_ctrl_t voice_ctrl [`SYNTH_VOICES]
);

  localparam int NV = `SYNTH_VOICES;

  logic                    cmd_pending;
  note_cmd_t               cmd_q;
  logic [NV-1:0]           busy;
  logic [`SYNTH_KEY_W-1:0] key_held [NV];
  logic [NV-1:0]           free_pick;
  logic [NV-1:0]           held_pick;
  logic [NV-1:0]           load_now;
  logic [NV-1:0]           rel_now;
  logic [NV-1:0]           pulse_any;

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      cmd_pending <= 1'b0;
    end else begin
      cmd_pending <= cmd_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid) begin
      cmd_q <= cmd;
    end
  end

  // Priority search from the top down, so the lowest matching voice is the last one written.
  always_comb begin
    free_pick = '0;
    held_pick = '0;
    for (int v = NV - 1; v >= 0; v--) begin
      if (!busy[v]) begin
        free_pick = NV'(1) << v;
      end
      if (busy[v] && key_held[v] == cmd_q.key) begin
        held_pick = NV'(1) << v;
      end
    end
    // A NOTE_ON with no free voice leaves both vectors empty and is dropped.
    load_now = (cmd_pending && cmd_q.op == NOTE_ON) ? free_pick : '0;
    rel_now  = (cmd_pending && cmd_q.op == NOTE_OFF) ? held_pick : '0;
  end

  always_ff @(posedge clk or negedge reset) begin
    if (!reset) begin
      busy <= '0;
      for (int v = 0; v < NV; v++) begin
        voice_ctrl[v] <= '0;
      end
    end else begin
      for (int v = 0; v < NV; v++) begin
        voice_ctrl[v].load <= load_now[v];
        voice_ctrl[v].rel  <= rel_now[v];
        voice_ctrl[v].key  <= cmd_q.key;
        voice_ctrl[v].wave <= cmd_q.wave;
        if (load_now[v]) begin
          busy[v] <= 1'b1;
        end else if (rel_now[v]) begin
          busy[v] <= 1'b0;
        end
      end
    end
  end

  // Keys are only compared while the voice is busy.
  always_ff @(posedge clk) begin
    for (int v = 0; v < NV; v++) begin
      if (load_now[v]) begin
        key_held[v] <= cmd_q.key;
      end
    end
  end

  always_comb begin
    for (int v = 0; v < NV; v++) begin
      pulse_any[v] = voice_ctrl[v].load | voice_ctrl[v].rel;
    end
  end

  // Each command touches one voice at most, so the voice bank sees a single pulse per cycle.
  a_one_pulse: assert property (@(posedge clk) disable iff (!reset) $onehot0(pulse_any))
    else $error("More than one voice pulsed in a cycle");

endmodule

// File: synth_pkg.sv
`include "synth_defs.svh"

package synth_pkg;

  // Command opcodes on the note input.
  typedef enum logic {
    NOTE_OFF = 1'b0,
    NOTE_ON  = 1'b1
  } synth_op_t;

  // Waveform selection, fixed for a voice at load time.
  typedef enum logic [1:0] {
    WAVE_SINE   = 2'd0,
    WAVE_SQUARE = 2'd1,
    WAVE_SAW    = 2'd2,
    WAVE_TRI    = 2'd3
  } wave_t;

  // One command from the outside, 10 bits.
  typedef struct packed {
    synth_op_t               op;
    logic [`SYNTH_KEY_W-1:0] key;
    wave_t                   wave;
  } note_cmd_t;

  // Dispatcher to voice control, 11 bits. Load and rel are one-cycle pulses.
  typedef struct packed {
    logic                    load;
    logic                    rel;
    logic [`SYNTH_KEY_W-1:0] key;
    wave_t                   wave;
  } voice_ctrl_t;

  // Registered voice output, 17 bits.
  typedef struct packed {
    logic                              active;
    logic signed [`SYNTH_SAMPLE_W-1:0] value;
  } voice_sample_t;

endpackage

// File: synth_defs.svh
`ifndef SYNTH_DEFS_SVH
`define SYNTH_DEFS_SVH

// Number of oscillator voices in the bank.
`define SYNTH_VOICES 4

// Width of each voice's phase accumulator.
// The waveform rules assume 16 bits.
`define SYNTH_PHASE_W 16

// Signed sample width, used for both voice and mixed output.
`define SYNTH_SAMPLE_W 16

// Key number width on the command input.
`define SYNTH_KEY_W 7

// Phase increment added per key unit on every step.
`define SYNTH_INC_SCALE 8

// Credits the mixer holds after reset.
// This is also the depth of the consumer's sample buffer.
`define SYNTH_CREDITS 4

`endif
